//--- bench/plotter_tests.txt
# test <name> <op count>, then one 64-bit op word in hex per line
# expect <net x steps> <net y steps> <pen down> <bad op count>
test abs_rel 2
0106403200000000
02014FF600000000
expect 120 40 0 0
test home_abs 3
0106403200000000
0400000000000000
0101E01400000000
expect 130 70 0 0
test pen_down 2
0300100000000000
0100A00A00000000
expect 10 10 1 0
test pen_up 2
0300100000000000
0300000000000000
expect 0 0 0 0
test bad_ops 4
0102802800000000
7F12345600000000
0000000000000000
0200500500000000
expect 45 45 0 2
test move_back 2
010C80C800000000
0103212C00000000
expect 50 300 0 0

//--- vlog.f
hdl/plotter_pkg.sv
hdl/op_store.sv
hdl/op_reader.sv
hdl/op_decoder.sv
hdl/step_gen.sv
hdl/plotter_top.sv
bench/plotter_properties.sv
bench/plotter_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= plotter_tb
FLIST ?= vlog.f
OBJ ?= obj_dir
LOG ?= sim.log

SRCS := $(shell cat $(FLIST))

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

//--- bench/plotter_tb.sv
module plotter_tb import plotter_pkg::*; ();

	logic out_x;
	logic rst;
	logic wr_en;
	logic [OP_BITS-1:0] wr_data;
	wire full;
	wire empty;
	wire idle;
	wire bad_op;
	wire step_x;
	wire dir_x;
	wire step_y;
	wire dir_y;
	wire servo_pwm;

	string t_name[$];
	int t_kind[$];
	int t_first[$];
	int t_nops[$];
	int t_ex_x[$];
	int t_ex_y[$];
	int t_pen[$];
	int t_bad[$];
	logic [OP_BITS-1:0] ops[$];

	int errors = 0;
	int checks = 0;
	int passed = 0;
	int cycles = 0;
	int limit = 100000;
	int unsigned rng = 30719;
	int mx;
	int my;
	int step_cnt_x = 0;
	int step_cnt_y = 0;
	int bad_cnt = 0;
	int hi_run = 0;
	int last_width = 0;
	logic step_x_q = 1'b0;
	logic step_y_q = 1'b0;

	plotter_top dut0 (
		.out_x(out_x),
		.rst(rst),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.full(full),
		.empty(empty),
		.idle(idle),
		.bad_op(bad_op),
		.step_x(step_x),
		.dir_x(dir_x),
		.step_y(step_y),
		.dir_y(dir_y),
		.servo_pwm(servo_pwm)
	);

	initial begin
		out_x = 1'b0;
		forever begin
			#4 out_x = ~out_x;
		end
	end

	always @(posedge out_x) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, idle never rose", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// Outputs settle after the rising edge, so the monitors look at the falling edge
	always @(negedge out_x) begin
		if (step_x && !step_x_q) begin
			step_cnt_x += dir_x ? 1 : -1;
		end
		if (step_y && !step_y_q) begin
			step_cnt_y += dir_y ? 1 : -1;
		end
		step_x_q = step_x;
		step_y_q = step_y;
		if (bad_op) begin
			bad_cnt++;
		end
		if (servo_pwm) begin
			hi_run++;
		end else begin
			if (hi_run > 0) begin
				last_width = hi_run;
			end
			hi_run = 0;
		end
	end

	function automatic int unsigned lcg_next();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng;
	endfunction

	function automatic logic [OP_BITS-1:0] make_op(input int cmd, input int a1, input int a2);
		return {cmd[7:0], a1[11:0], a2[11:0], 12'h0, 12'h0, 8'h0};
	endfunction

	// Reference position model that returns the number of steps an op costs
	function automatic int model_apply(input logic [OP_BITS-1:0] op);
		int c;
		int a1;
		int a2;
		int tx;
		int ty;
		int st;
		c = op[63:56];
		a1 = op[55:44];
		a2 = op[43:32];
		if (c == 1) begin
			tx = a1;
			ty = a2;
		end else if (c == 2) begin
			tx = (mx + a1) % 4096;
			ty = (my + a2) % 4096;
		end else begin
			if (c == 4) begin
				mx = 0;
				my = 0;
			end
			return 0;
		end
		st = (tx > mx ? tx - mx : mx - tx) + (ty > my ? ty - my : my - ty);
		mx = tx;
		my = ty;
		return st;
	endfunction

	task automatic check(input string name, input string what, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("mismatch %s %s expected %0d actual %0d", name, what, exp, act);
		end
	endtask

	task automatic next_line(input int fd, output string line);
		int n;
		line = "";
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				return;
			end
		end
		line = "";
	endtask

	task automatic load_tests(input int fd);
		string line;
		string nm;
		int cnt;
		int ex;
		int ey;
		int ep;
		int eb;
		logic [OP_BITS-1:0] w;
		next_line(fd, line);
		while (line != "") begin
			if ($sscanf(line, "test %s %d", nm, cnt) == 2) begin
				t_name.push_back(nm);
				t_kind.push_back(0);
				t_first.push_back(ops.size());
				t_nops.push_back(cnt);
				for (int k = 0; k < cnt; k++) begin
					next_line(fd, line);
					void'($sscanf(line, "%h", w));
					ops.push_back(w);
				end
				next_line(fd, line);
				void'($sscanf(line, "expect %d %d %d %d", ex, ey, ep, eb));
				t_ex_x.push_back(ex);
				t_ex_y.push_back(ey);
				t_pen.push_back(ep);
				t_bad.push_back(eb);
			end
			next_line(fd, line);
		end
	endtask

	task automatic add_generated(input string nm, input int kind, input int first);
		t_name.push_back(nm);
		t_kind.push_back(kind);
		t_first.push_back(first);
		t_nops.push_back(ops.size() - first);
		t_ex_x.push_back(0);
		t_ex_y.push_back(0);
		t_pen.push_back(0);
		t_bad.push_back(0);
	endtask

	task automatic run_test(input int t);
		int base_x;
		int base_y;
		int base_bad;
		int accepted;
		int ex_x;
		int ex_y;
		int err0;
		logic saw_full;
		@(posedge out_x);
		#1 rst = 1'b1;
		repeat (16) @(posedge out_x);
		#1 rst = 1'b0;
		base_x = step_cnt_x;
		base_y = step_cnt_y;
		base_bad = bad_cnt;
		err0 = errors;
		check(t_name[t], "empty after reset", 1, int'(empty));
		check(t_name[t], "full after reset", 0, int'(full));
		check(t_name[t], "idle after reset", 1, int'(idle));
		mx = 0;
		my = 0;
		accepted = 0;
		saw_full = 1'b0;
		for (int i = 0; i < t_nops[t]; i++) begin
			@(posedge out_x);
			#1;
			if (full) begin
				saw_full = 1'b1;
			end else begin
				accepted++;
				void'(model_apply(ops[t_first[t] + i]));
			end
			wr_en = 1'b1;
			wr_data = ops[t_first[t] + i];
		end
		@(posedge out_x);
		#1 wr_en = 1'b0;
		repeat (3) @(posedge out_x);
		do begin
			@(posedge out_x);
			#1;
		end while (!idle);
		// Two servo periods so the last pen state shows up in a full pulse
		repeat (2 * SERVO_PERIOD + 4) @(posedge out_x);
		if (t_kind[t] == 0) begin
			ex_x = t_ex_x[t];
			ex_y = t_ex_y[t];
		end else begin
			ex_x = mx;
			ex_y = my;
		end
		check(t_name[t], "x steps", ex_x, step_cnt_x - base_x);
		check(t_name[t], "y steps", ex_y, step_cnt_y - base_y);
		check(t_name[t], "servo width", t_pen[t] != 0 ? SERVO_DOWN_W : SERVO_UP_W, last_width);
		check(t_name[t], "bad ops", t_bad[t], bad_cnt - base_bad);
		if (t_kind[t] == 2) begin
			check(t_name[t], "full seen", 1, int'(saw_full));
			check(t_name[t], "at least 64 accepted", 1, int'(accepted >= STORE_ROWS));
		end
		if (errors == err0) begin
			passed++;
			$display("test %s ok", t_name[t]);
		end else begin
			$display("test %s failed", t_name[t]);
		end
	endtask

	initial begin
		int fd;
		int first;
		int steps;
		rst = 1'b1;
		wr_en = 1'b0;
		wr_data = '0;
		fd = $fopen("bench/plotter_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/plotter_tests.txt");
			errors++;
		end else begin
			load_tests(fd);
			$fclose(fd);
		end

		first = ops.size();
		ops.push_back(make_op(1, 2048, 2048));
		for (int i = 0; i < 24; i++) begin
			ops.push_back(make_op(2, ((lcg_next() >> 16) % 128) - 64,
				((lcg_next() >> 16) % 128) - 64));
		end
		add_generated("random_burst", 1, first);

		// The first move keeps the step generator busy while the store fills
		first = ops.size();
		ops.push_back(make_op(2, 100, 0));
		for (int i = 0; i < 69; i++) begin
			ops.push_back(make_op(2, 1, 1));
		end
		add_generated("store_limit", 2, first);

		limit = 0;
		for (int t = 0; t < t_name.size(); t++) begin
			mx = 0;
			my = 0;
			steps = 0;
			for (int i = 0; i < t_nops[t]; i++) begin
				steps += model_apply(ops[t_first[t] + i]);
			end
			limit += steps * 6 + 500 + 2 * SERVO_PERIOD + 40 + t_nops[t] * 8;
		end

		for (int t = 0; t < t_name.size(); t++) begin
			run_test(t);
		end
		$display("tests %0d passed %0d checks %0d errors %0d",
			t_name.size(), passed, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- bench/plotter_properties.sv
module plotter_properties (
	input logic out_x,
	input logic rst,
	input logic step_x,
	input logic step_y,
	input logic dir_x,
	input logic dir_y,
	input logic rd_trigger,
	input logic empty,
	input logic op_trigger
);

	// Axes take turns, so both motors never step together
	assert property (@(posedge out_x) disable iff (rst) !(step_x && step_y))
		else $error("step_x and step_y high together");

	assert property (@(posedge out_x) disable iff (rst) step_x |=> (!step_x || $stable(dir_x)))
		else $error("dir_x changed during a step pulse");

	assert property (@(posedge out_x) disable iff (rst) step_y |=> (!step_y || $stable(dir_y)))
		else $error("dir_y changed during a step pulse");

	assert property (@(posedge out_x) disable iff (rst) rd_trigger |-> !empty)
		else $error("rd_trigger fired on an empty store");

	assert property (@(posedge out_x) disable iff (rst) op_trigger |=> !op_trigger)
		else $error("op_trigger longer than one cycle");

endmodule

bind plotter_top plotter_properties props0 (
	.out_x(out_x),
	.rst(rst),
	.step_x(step_x),
	.step_y(step_y),
	.dir_x(dir_x),
	.dir_y(dir_y),
	.rd_trigger(rd_trigger),
	.empty(empty),
	.op_trigger(op_trigger)
);

//--- hdl/plotter_top.sv
module plotter_top import plotter_pkg::*; (
	input logic out_x,
	input logic rst,
	input logic wr_en,
	input logic [OP_BITS-1:0] wr_data,
	output logic full,
	output logic empty,
	output logic idle,
	output logic bad_op,
	output logic step_x,
	output logic dir_x,
	output logic step_y,
	output logic dir_y,
	output logic servo_pwm
);

	logic rd_trigger;
	logic [OP_BITS-1:0] rd_data;
	logic rd_done;
	logic store_rdy;
	logic op_trigger;
	logic [OP_BITS-1:0] op_data;
	logic holding;
	logic dec_rdy;
	logic move_rdy;
	logic move_trigger;
	logic [POS_BITS-1:0] steps_x;
	logic dir_x_req;
	logic [POS_BITS-1:0] steps_y;
	logic dir_y_req;
	logic pen_down_req;

	// Nothing stored, nothing fetched and both later stages waiting
	assign idle = empty && !holding && dec_rdy && move_rdy;

	op_store store0 (
		.out_x(out_x),
		.rst(rst),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_trigger(rd_trigger),
		.rd_data(rd_data),
		.rd_done(rd_done),
		.store_rdy(store_rdy),
		.empty(empty),
		.full(full)
	);

	op_reader reader0 (
		.out_x(out_x),
		.rst(rst),
		.empty(empty),
		.store_rdy(store_rdy),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.dec_rdy(dec_rdy),
		.rd_trigger(rd_trigger),
		.op_trigger(op_trigger),
		.op_data(op_data),
		.holding(holding)
	);

	op_decoder decoder0 (
		.out_x(out_x),
		.rst(rst),
		.op_trigger(op_trigger),
		.op_data(op_data),
		.move_rdy(move_rdy),
		.dec_rdy(dec_rdy),
		.move_trigger(move_trigger),
		.steps_x(steps_x),
		.dir_x_req(dir_x_req),
		.steps_y(steps_y),
		.dir_y_req(dir_y_req),
		.pen_down_req(pen_down_req),
		.bad_op(bad_op)
	);

	step_gen step0 (
		.out_x(out_x),
		.rst(rst),
		.move_trigger(move_trigger),
		.steps_x(steps_x),
		.dir_x_req(dir_x_req),
		.steps_y(steps_y),
		.dir_y_req(dir_y_req),
		.pen_down_req(pen_down_req),
		.move_rdy(move_rdy),
		.move_done(),
		.step_x(step_x),
		.dir_x(dir_x),
		.step_y(step_y),
		.dir_y(dir_y),
		.servo_pwm(servo_pwm)
	);

endmodule

//--- hdl/step_gen.sv
module step_gen import plotter_pkg::*; (
	input logic out_x,
	input logic rst,
	input logic move_trigger,
	input logic [POS_BITS-1:0] steps_x,
	input logic dir_x_req,
	input logic [POS_BITS-1:0] steps_y,
	input logic dir_y_req,
	input logic pen_down_req,
	output logic move_rdy,
	output logic move_done,
	output logic step_x,
	output logic dir_x,
	output logic step_y,
	output logic dir_y,
	output logic servo_pwm
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_X,
		S_Y,
		S_DONE
	} state_t;

	state_t state;
	logic [POS_BITS-1:0] rem_x;
	logic [POS_BITS-1:0] rem_y;
	logic [STEP_CNT_BITS-1:0] cnt;
	logic pulse_end;
	logic pulse_high;
	logic pen_q;
	logic [SERVO_CNT_BITS-1:0] per_cnt;
	logic [SERVO_CNT_BITS-1:0] width_q;

	assign move_rdy = (state == S_IDLE);
	assign move_done = (state == S_DONE);

	assign pulse_high = (cnt < STEP_CNT_BITS'(STEP_HIGH));
	assign pulse_end = (cnt == STEP_CNT_BITS'(STEP_HIGH + STEP_LOW - 1));

	assign step_x = (state == S_X) && pulse_high;
	assign step_y = (state == S_Y) && pulse_high;

	// Each pulse takes STEP_HIGH plus STEP_LOW cycles and all X pulses come first
	always_ff @(posedge out_x) begin
		if (rst) begin
			state <= S_IDLE;
			cnt <= '0;
			dir_x <= 1'b0;
			dir_y <= 1'b0;
			pen_q <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (move_trigger) begin
						dir_x <= dir_x_req;
						dir_y <= dir_y_req;
						pen_q <= pen_down_req;
						if (steps_x != '0) begin
							state <= S_X;
						end else if (steps_y != '0) begin
							state <= S_Y;
						end else begin
							state <= S_DONE;
						end
					end
				end
				S_X: begin
					cnt <= pulse_end ? '0 : cnt + 1'b1;
					if (pulse_end && rem_x == POS_BITS'(1)) begin
						state <= (rem_y != '0) ? S_Y : S_DONE;
					end
				end
				S_Y: begin
					cnt <= pulse_end ? '0 : cnt + 1'b1;
					if (pulse_end && rem_y == POS_BITS'(1)) begin
						state <= S_DONE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge out_x) begin
		if (state == S_IDLE && move_trigger) begin
			rem_x <= steps_x;
			rem_y <= steps_y;
		end else if (pulse_end && state == S_X) begin
			rem_x <= rem_x - 1'b1;
		end else if (pulse_end && state == S_Y) begin
			rem_y <= rem_y - 1'b1;
		end
	end

	// New pen width is taken on the last count so it starts with the next period
	always_ff @(posedge out_x) begin
		if (rst) begin
			per_cnt <= '0;
			width_q <= SERVO_CNT_BITS'(SERVO_UP_W);
		end else if (per_cnt == SERVO_CNT_BITS'(SERVO_PERIOD - 1)) begin
			per_cnt <= '0;
			width_q <= pen_q ? SERVO_CNT_BITS'(SERVO_DOWN_W) : SERVO_CNT_BITS'(SERVO_UP_W);
		end else begin
			per_cnt <= per_cnt + 1'b1;
		end
	end

	assign servo_pwm = (per_cnt < width_q);

endmodule

//--- hdl/op_decoder.sv
module op_decoder import plotter_pkg::*; (
	input logic out_x,
	input logic rst,
	input logic op_trigger,
	input logic [OP_BITS-1:0] op_data,
	input logic move_rdy,
	output logic dec_rdy,
	output logic move_trigger,
	output logic [POS_BITS-1:0] steps_x,
	output logic dir_x_req,
	output logic [POS_BITS-1:0] steps_y,
	output logic dir_y_req,
	output logic pen_down_req,
	output logic bad_op
);

	typedef enum logic [1:0] {
		S_READY,
		S_ISSUE,
		S_SKIP
	} state_t;

	state_t state;
	logic accept;
	logic [CMD_BITS-1:0] cmd;
	logic [ARG_BITS-1:0] arg_1;
	logic [ARG_BITS-1:0] arg_2;
	logic [POS_BITS-1:0] pos_x;
	logic [POS_BITS-1:0] pos_y;
	logic [POS_BITS-1:0] tgt_x;
	logic [POS_BITS-1:0] tgt_y;
	logic up_x;
	logic up_y;
	logic [POS_BITS-1:0] dist_x;
	logic [POS_BITS-1:0] dist_y;

	assign cmd = op_data[CMD_LSB +: CMD_BITS];
	assign arg_1 = op_data[ARG1_LSB +: ARG_BITS];
	assign arg_2 = op_data[ARG2_LSB +: ARG_BITS];

	assign accept = op_trigger && dec_rdy;
	assign dec_rdy = (state == S_READY);
	assign move_trigger = (state == S_ISSUE) && move_rdy;

	// A relative move adds the two's complement delta, so the sum wraps at 4096
	always_comb begin
		if (cmd == CMD_MOVE_ABS) begin
			tgt_x = arg_1;
			tgt_y = arg_2;
		end else begin
			tgt_x = pos_x + arg_1;
			tgt_y = pos_y + arg_2;
		end
		up_x = (tgt_x >= pos_x);
		up_y = (tgt_y >= pos_y);
		dist_x = up_x ? tgt_x - pos_x : pos_x - tgt_x;
		dist_y = up_y ? tgt_y - pos_y : pos_y - tgt_y;
	end

	always_ff @(posedge out_x) begin
		if (rst) begin
			state <= S_READY;
			pos_x <= '0;
			pos_y <= '0;
			pen_down_req <= 1'b0;
			bad_op <= 1'b0;
		end else begin
			bad_op <= 1'b0;
			case (state)
				S_READY: begin
					if (accept) begin
						case (cmd)
							CMD_MOVE_ABS, CMD_MOVE_REL: begin
								pos_x <= tgt_x;
								pos_y <= tgt_y;
								state <= S_ISSUE;
							end
							CMD_PEN: begin
								pen_down_req <= |arg_1;
								state <= S_ISSUE;
							end
							CMD_HOME: begin
								pos_x <= '0;
								pos_y <= '0;
								state <= S_SKIP;
							end
							default: begin
								bad_op <= 1'b1;
								state <= S_SKIP;
							end
						endcase
					end
				end
				S_ISSUE: begin
					if (move_rdy) begin
						state <= S_READY;
					end
				end
				default: begin
					state <= S_READY;
				end
			endcase
		end
	end

	// PEN goes out as a job with no steps so the servo picks it up in order
	always_ff @(posedge out_x) begin
		if (accept) begin
			steps_x <= (cmd == CMD_PEN) ? '0 : dist_x;
			steps_y <= (cmd == CMD_PEN) ? '0 : dist_y;
			dir_x_req <= up_x;
			dir_y_req <= up_y;
		end
	end

endmodule

//--- hdl/op_reader.sv
module op_reader import plotter_pkg::*; (
	input logic out_x,
	input logic rst,
	input logic empty,
	input logic store_rdy,
	input logic rd_done,
	input logic [OP_BITS-1:0] rd_data,
	input logic dec_rdy,
	output logic rd_trigger,
	output logic op_trigger,
	output logic [OP_BITS-1:0] op_data,
	output logic holding
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_HOLD
	} state_t;

	state_t state;

	// Fetch only while the buffer is free, so at most one word sits here
	assign rd_trigger = (state == S_IDLE) && !empty && store_rdy;

	// Hand over as soon as the decoder is ready
	assign op_trigger = (state == S_HOLD) && dec_rdy;

	// A word on its way from the store counts as held
	assign holding = (state != S_IDLE);

	always_ff @(posedge out_x) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (rd_trigger) begin
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (rd_done) begin
						state <= S_HOLD;
					end
				end
				S_HOLD: begin
					if (op_trigger) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge out_x) begin
		if (state == S_WAIT && rd_done) begin
			op_data <= rd_data;
		end
	end

endmodule

//--- hdl/op_store.sv
module op_store import plotter_pkg::*; (
	input logic out_x,
	input logic rst,
	input logic wr_en,
	input logic [OP_BITS-1:0] wr_data,
	input logic rd_trigger,
	output logic [OP_BITS-1:0] rd_data,
	output logic rd_done,
	output logic store_rdy,
	output logic empty,
	output logic full
);

	logic [OP_BITS-1:0] mem [STORE_ROWS];
	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [ADDR_BITS:0] count;
	logic do_wr;
	logic do_rd;

	assign full = (count == (ADDR_BITS + 1)'(STORE_ROWS));
	assign empty = (count == '0);

	// Writes into a full store are dropped without notice
	assign do_wr = wr_en && !full;
	assign do_rd = rd_trigger && !empty;

	// The store takes no new trigger in the cycle it hands a word back
	assign store_rdy = !rd_done;

	always_ff @(posedge out_x) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge out_x) begin
		if (do_rd) begin
			rd_data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge out_x) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rd_done <= 1'b0;
		end else begin
			rd_done <= do_rd;
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// A read and a write in the same cycle leave the count alone
			case ({do_wr, do_rd})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

endmodule

//--- hdl/plotter_pkg.sv
package plotter_pkg;

	// Width of one plot operation as the host writes it
	localparam int OP_BITS = 64;
	localparam int CMD_BITS = 8;
	localparam int ARG_BITS = 12;
	localparam int FLAG_BITS = 8;

	// Field positions are counted up from the flag byte at the bottom of the word
	localparam int ARG2_LSB = FLAG_BITS + 2 * ARG_BITS;
	localparam int ARG1_LSB = ARG2_LSB + ARG_BITS;
	localparam int CMD_LSB = ARG1_LSB + ARG_BITS;

	localparam logic [CMD_BITS-1:0] CMD_MOVE_ABS = 8'd1;
	localparam logic [CMD_BITS-1:0] CMD_MOVE_REL = 8'd2;
	localparam logic [CMD_BITS-1:0] CMD_PEN = 8'd3;
	localparam logic [CMD_BITS-1:0] CMD_HOME = 8'd4;

	// Positions are unsigned and wrap modulo 4096
	localparam int POS_BITS = 12;

	localparam int STORE_ROWS = 64;
	localparam int ADDR_BITS = $clog2(STORE_ROWS);

	// A step pulse is high for STEP_HIGH cycles and then low for STEP_LOW cycles
	localparam int STEP_HIGH = 3;
	localparam int STEP_LOW = 3;
	localparam int STEP_CNT_BITS = $clog2(STEP_HIGH + STEP_LOW);

	localparam int SERVO_PERIOD = 200;
	localparam int SERVO_UP_W = 10;
	localparam int SERVO_DOWN_W = 20;
	localparam int SERVO_CNT_BITS = $clog2(SERVO_PERIOD);

endpackage
